// File: samples.hex
// 64 sample words, one 64-bit hex word each, two per line, index 0 first.
// every byte pair holds the index so the 16-bit lane swap is visible.
00A100B200C300D4 01A101B201C301D4
02A102B202C302D4 03A103B203C303D4
04A104B204C304D4 05A105B205C305D4
06A106B206C306D4 07A107B207C307D4
08A108B208C308D4 09A109B209C309D4
0AA10AB20AC30AD4 0BA10BB20BC30BD4
0CA10CB20CC30CD4 0DA10DB20DC30DD4
0EA10EB20EC30ED4 0FA10FB20FC30FD4
10A110B210C310D4 11A111B211C311D4
12A112B212C312D4 13A113B213C313D4
14A114B214C314D4 15A115B215C315D4
16A116B216C316D4 17A117B217C317D4
18A118B218C318D4 19A119B219C319D4
1AA11AB21AC31AD4 1BA11BB21BC31BD4
1CA11CB21CC31CD4 1DA11DB21DC31DD4
1EA11EB21EC31ED4 1FA11FB21FC31FD4
20A120B220C320D4 21A121B221C321D4
22A122B222C322D4 23A123B223C323D4
24A124B224C324D4 25A125B225C325D4
26A126B226C326D4 27A127B227C327D4
28A128B228C328D4 29A129B229C329D4
2AA12AB22AC32AD4 2BA12BB22BC32BD4
2CA12CB22CC32CD4 2DA12DB22DC32DD4
2EA12EB22EC32ED4 2FA12FB22FC32FD4
30A130B230C330D4 31A131B231C331D4
32A132B232C332D4 33A133B233C333D4
34A134B234C334D4 35A135B235C335D4
36A136B236C336D4 37A137B237C337D4
38A138B238C338D4 39A139B239C339D4
3AA13AB23AC33AD4 3BA13BB23BC33BD4
3CA13CB23CC33CD4 3DA13DB23DC33DD4
3EA13EB23EC33ED4 3FA13FB23FC33FD4

// File: filelist.f
hdl/pkt_src_pkg.sv
hdl/setting_reg.sv
hdl/sample_rom.sv
hdl/file_source.sv
hdl/axi_packet_gate.sv
hdl/file_source_top.sv
testbench/tb_file_source.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -f filelist.f --top-module tb_file_source -o tb_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

out=$(./obj_dir/tb_sim 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
   exit 0
else
   echo "pass message not found"
   exit 1
fi

// File: testbench/tb_file_source.sv
/*
 * directed testbench for file_source_top, run from the project root so samples.hex is found.
 * source stops are timed from internal source state so that len never changes mid-packet.
 */
`timescale 1ns/1ps

module tb_file_source
   import pkt_src_pkg::*;
();

   logic     clk;
   logic     reset;
   set_bus_t i_set;
   stream_t  o_stream;
   logic     o_tvalid;
   logic     i_tready;

   word_t    file_words [ROM_DEPTH];   // raw file contents, before the lane swap.
   sid_t     exp_sid;
   int       exp_seq;
   int       exp_index;
   int       cycle;
   logic     rand_ready;               // random back-pressure when set.
   logic     stall_prev;
   stream_t  data_prev;
   stream_t  rx_words [$];             // accepted output words, oldest first.
   int       rx_cycles [$];            // cycle each of those words was seen.

   file_source_top i_dut (
      .clk(clk), .reset(reset), .i_set(i_set),
      .o_stream(o_stream), .o_tvalid(o_tvalid), .i_tready(i_tready)
   );

   always #10 clk = ~clk;

   always @(posedge clk)
   begin
      cycle <= cycle + 1;
      if (rand_ready)
         i_tready <= 1'($urandom % 2);
      else
         i_tready <= 1'b1;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // checking helpers.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic stop_on_error();
      $display("Checks failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp)
      else
      begin
         $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_true(input bit cond, input string what);
      assert (cond)
      else
      begin
         $display("%s", what);
         stop_on_error();
      end
   endtask

   // expected sample: bytes exchanged inside every 16-bit lane.
   function automatic word_t swap_lanes(input word_t w);
      word_t r;
      for (int lane = 0; lane < DATA_W / 16; lane++)
         r[lane*16 +: 16] = {w[lane*16 +: 8], w[lane*16+8 +: 8]};
      return r;
   endfunction

   // output monitor, records every accepted word and checks the hold rule.
   always @(negedge clk)
   begin
      if (!reset)
      begin
         if (stall_prev)
         begin
            check_eq("o_tvalid", o_tvalid, 1);
            check_eq("o_stream.tdata", o_stream.tdata, data_prev.tdata);
            check_eq("o_stream.tlast", o_stream.tlast, data_prev.tlast);
         end
         stall_prev = o_tvalid && !i_tready;
         data_prev  = o_stream;
         if (o_tvalid && i_tready)
         begin
            rx_words.push_back(o_stream);
            rx_cycles.push_back(cycle);
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // bus and stream tasks.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic write_setting(input set_addr_t addr, input set_data_t data);
      @(posedge clk);
      i_set <= '{stb: 1'b1, addr: addr, data: data};
      @(posedge clk);
      i_set.stb <= 1'b0;
      if (addr == ADDR_SID)
      begin
         exp_sid = data;   // a new id restarts the numbering.
         exp_seq = 0;
      end
   endtask

   // next accepted output word in order, with the cycle it was seen.
   task automatic get_word(output stream_t w, output int at_cycle);
      int waited;
      waited = 0;
      while (rx_words.size() == 0)
      begin
         @(negedge clk);
         waited++;
         check_true(waited < 4000, "timeout waiting for an output word");
      end
      w        = rx_words.pop_front();
      at_cycle = rx_cycles.pop_front();
   endtask

   // header then len payload words, all checked against the model.
   task automatic receive_packet(input int len, output int tlast_cycle);
      stream_t w;
      word_t   head;
      int      t;
      get_word(w, t);
      head = {4'b0000, exp_seq[11:0], 16'(len * 8 + 8), exp_sid};
      check_eq("header tdata", w.tdata, head);
      check_eq("header tlast", w.tlast, 0);
      exp_seq = (exp_seq + 1) % 4096;
      for (int i = 1; i <= len; i++)
      begin
         get_word(w, t);
         check_eq("payload tdata", w.tdata, swap_lanes(file_words[exp_index]));
         check_eq("payload tlast", w.tlast, (i == len));
         exp_index = (exp_index + 1) % ROM_DEPTH;   // index runs on across packets.
      end
      tlast_cycle = t;
   endtask

   // clear len exactly as the source accepts its last payload word.
   task automatic stop_source();
      int waited;
      rand_ready = 1'b0;
      write_setting(ADDR_RATE, 0);
      waited = 0;
      forever
      begin
         @(negedge clk);
         if (i_dut.u_src.state == ST_DATA && i_dut.u_src.len > 1 &&
             i_dut.u_src.count == i_dut.u_src.len - 1 && i_dut.u_src.rate == 0 &&
             i_dut.u_src.o_tvalid && i_dut.u_src.i_tready && i_dut.u_gate.fill < 60)
            break;
         waited++;
         check_true(waited < 5000, "timeout waiting for the source to near a packet end");
      end
      write_setting(ADDR_LEN, 0);
   endtask

   // takes every packet still recorded or held in the gate.
   task automatic drain_packets(input int len);
      int t;
      repeat (3) @(negedge clk);
      while (o_tvalid || rx_words.size() != 0)
      begin
         receive_packet(len, t);
         @(negedge clk);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // tests.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic test_single_packet();
      int t;
      write_setting(ADDR_SID, 32'h1234_5678);
      write_setting(ADDR_RATE, 0);
      write_setting(ADDR_LEN, 4);
      receive_packet(4, t);   // seqnum 0, 40 bytes, samples 0 to 3.
      stop_source();
      drain_packets(4);
   endtask

   task automatic test_sequence();
      int t;
      write_setting(ADDR_SID, 32'hCAFE_0001);
      write_setting(ADDR_LEN, 4);
      repeat (3) receive_packet(4, t);
      stop_source();
      drain_packets(4);
      write_setting(ADDR_SID, 32'h0BAD_F00D);
      write_setting(ADDR_LEN, 4);
      receive_packet(4, t);
      stop_source();
      drain_packets(4);
   endtask

   task automatic test_wrap();
      int t;
      write_setting(ADDR_LEN, 30);
      repeat (4) receive_packet(30, t);   // 120 words, past word 63.
      stop_source();
      drain_packets(30);
   endtask

   task automatic test_backpressure();
      int t;
      rand_ready = 1'b1;
      write_setting(ADDR_LEN, 20);
      repeat (6) receive_packet(20, t);
      stop_source();
      drain_packets(20);
   endtask

   task automatic test_rate();
      int t0;
      int t1;
      write_setting(ADDR_RATE, 3);
      write_setting(ADDR_LEN, 5);
      receive_packet(5, t0);
      repeat (3)
      begin
         receive_packet(5, t1);
         check_true(t1 - t0 >= 5 * 4, "packets left faster than the rate allows");
         t0 = t1;
      end
      stop_source();
      drain_packets(5);
   endtask

   task automatic test_stop();
      int t;
      write_setting(ADDR_LEN, 8);
      receive_packet(8, t);
      stop_source();
      drain_packets(8);
      repeat (500)
      begin
         @(negedge clk);
         check_eq("o_tvalid", o_tvalid, 0);
      end
   endtask

   initial
   begin
      clk         = 1'b0;
      reset       = 1'b1;
      i_set       = '0;
      i_tready    = 1'b0;
      rand_ready  = 1'b0;
      stall_prev  = 1'b0;
      data_prev   = '0;
      cycle       = 0;
      exp_sid     = '0;
      exp_seq     = 0;
      exp_index   = 0;
      void'($urandom(32'h2263_7f93));
      $readmemh(ROM_FILE, file_words);
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      test_single_packet();
      test_sequence();
      test_wrap();
      test_backpressure();
      test_rate();
      test_stop();
      $display("All checks passed");
      $finish;
   end

endmodule

// File: hdl/file_source_top.sv
/*
 * packet source followed by the packet gate.
 * downstream only ever sees whole packets.
 */
`timescale 1ns/1ps

module file_source_top
   import pkt_src_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  set_bus_t i_set,
   output stream_t  o_stream,
   output logic     o_tvalid,
   input  logic     i_tready
);

   stream_t src_stream;   // source to gate.
   logic    src_tvalid;
   logic    src_tready;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // source.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   file_source u_src (
      .clk      (clk),
      .reset    (reset),
      .i_set    (i_set),
      .o_stream (src_stream),
      .o_tvalid (src_tvalid),
      .i_tready (src_tready)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // whole-packet gate.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   axi_packet_gate u_gate (
      .clk      (clk),
      .reset    (reset),
      .i_stream (src_stream),
      .i_tvalid (src_tvalid),
      .o_tready (src_tready),
      .o_stream (o_stream),
      .o_tvalid (o_tvalid),
      .i_tready (i_tready)
   );

endmodule

// File: hdl/axi_packet_gate.sv
/*
 * store-and-forward buffer that releases a packet only once its last word is in.
 * a packet longer than GATE_DEPTH words stalls the input for good.
 */
`timescale 1ns/1ps

module axi_packet_gate
   import pkt_src_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  stream_t i_stream,
   input  logic    i_tvalid,
   output logic    o_tready,
   output stream_t o_stream,
   output logic    o_tvalid,
   input  logic    i_tready
);

   stream_t            mem [GATE_DEPTH];   // words with their tlast bits.
   logic [GATE_AW-1:0] wr_ptr;
   logic [GATE_AW-1:0] rd_ptr;
   logic [GATE_AW:0]   fill;               // words held, 0 to GATE_DEPTH.
   logic [GATE_AW:0]   pkt_cnt;            // whole packets held.
   logic               wr_en;
   logic               rd_en;
   logic               wr_commit;
   logic               rd_done;

   assign wr_en     = i_tvalid && o_tready;
   assign rd_en     = o_tvalid && i_tready;
   assign wr_commit = wr_en && i_stream.tlast;
   assign rd_done   = rd_en && o_stream.tlast;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // circular store.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_ptr] <= i_stream;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;   // pointers wrap on their own.
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // occupancy.
   always_ff @(posedge clk)
   begin
      if (reset)
         fill <= '0;
      else
      begin
         case ({wr_en, rd_en})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
      end
   end

   // committed packets, up on a stored tlast and down on a sent one.
   always_ff @(posedge clk)
   begin
      if (reset)
         pkt_cnt <= '0;
      else
      begin
         case ({wr_commit, rd_done})
            2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
            2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
            default: pkt_cnt <= pkt_cnt;
         endcase
      end
   end

   assign o_tready = (fill != (GATE_AW+1)'(GATE_DEPTH));
   assign o_tvalid = (pkt_cnt != '0);
   assign o_stream = mem[rd_ptr];   // head word stays put until it is taken.

endmodule

// File: hdl/file_source.sv
/*
 * repeating header plus payload source, running while the length is nonzero.
 * a length write mid-packet takes effect at once; write it only between packets.
 */
`timescale 1ns/1ps

module file_source
   import pkt_src_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  set_bus_t i_set,
   output stream_t  o_stream,
   output logic     o_tvalid,
   input  logic     i_tready
);

   sid_t       sid;
   len_t       len;
   rate_t      rate;
   logic       sid_changed;
   src_state_t state;
   len_t       count;       // payload words sent, 1-based in ST_DATA.
   seqnum_t    seqnum;
   rom_addr_t  index;       // keeps running across packets.
   rate_t      timer;
   len_t       byte_len;
   word_t      sample;
   logic       xfer;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // setting registers and sample memory.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   setting_reg #(.MY_ADDR(ADDR_SID), .WIDTH(32)) u_sid_reg (
      .clk(clk), .reset(reset), .i_set(i_set),
      .o_value(sid), .o_changed(sid_changed)
   );

   setting_reg #(.MY_ADDR(ADDR_LEN), .WIDTH(16)) u_len_reg (
      .clk(clk), .reset(reset), .i_set(i_set),
      .o_value(len), .o_changed()
   );

   setting_reg #(.MY_ADDR(ADDR_RATE), .WIDTH(16)) u_rate_reg (
      .clk(clk), .reset(reset), .i_set(i_set),
      .o_value(rate), .o_changed()
   );

   sample_rom u_rom (
      .clk(clk), .i_addr(index), .o_sample(sample)
   );

   assign xfer = o_tvalid && i_tready;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // packet FSM.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= ST_IDLE;
         count <= '0;
         index <= '0;
      end
      else
      begin
         case (state)
            ST_IDLE:
               if (len != '0)
                  state <= ST_HEAD;
            ST_HEAD:
               if (xfer)
               begin
                  count <= len_t'(1);
                  state <= ST_DATA;
               end
            ST_DATA:
               if (xfer)
               begin
                  index <= index + 1'b1;   // wraps at the end of the memory.
                  if (count == len)
                  begin
                     state <= ST_IDLE;
                     count <= '0;
                  end
                  else
                     count <= count + 1'b1;
               end
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   // a new stream id restarts numbering.
   always_ff @(posedge clk)
   begin
      if (reset || sid_changed)
         seqnum <= '0;
      else if (state == ST_HEAD && xfer)
         seqnum <= seqnum + 1'b1;
   end

   // rate timer, held at zero while a word waits for ready.
   always_ff @(posedge clk)
   begin
      if (reset)
         timer <= '0;
      else if (timer != '0)
         timer <= timer - 1'b1;
      else if (!(o_tvalid && !i_tready))
         timer <= rate;
   end

   assign byte_len = {len[12:0], 3'b000} + len_t'(8);   // payload plus header, in bytes.

   assign o_stream.tdata = (state == ST_HEAD) ? {4'b0000, seqnum, byte_len, sid} : sample;
   assign o_stream.tlast = (state == ST_DATA) && (count == len);
   assign o_tvalid       = (state == ST_HEAD || state == ST_DATA) && (timer == '0);

endmodule

// File: hdl/sample_rom.sv
/*
 * sample memory loaded from ROM_FILE at elaboration, read combinationally.
 * bytes inside each 16-bit lane are exchanged to fix the file byte order.
 */
`timescale 1ns/1ps

module sample_rom
   import pkt_src_pkg::*;
(
   input  logic      clk,        // reserved for a registered read.
   input  rom_addr_t i_addr,
   output word_t     o_sample
);

   word_t mem [ROM_DEPTH];
   word_t raw;

   initial
   begin
      $readmemh(ROM_FILE, mem);
   end

   assign raw = mem[i_addr];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // byte swap per 16-bit lane.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   for (genvar lane = 0; lane < DATA_W / 16; lane++)
   begin : g_lane
      assign o_sample[lane*16+15 -: 8] = raw[lane*16+7 -: 8];
      assign o_sample[lane*16+7 -: 8]  = raw[lane*16+15 -: 8];
   end

endmodule

// File: hdl/setting_reg.sv
/*
 * one addressed setting register, loaded one cycle after a matching strobe.
 * o_changed pulses in the cycle the new value appears.
 */
`timescale 1ns/1ps

module setting_reg
   import pkt_src_pkg::*;
#(
   parameter set_addr_t MY_ADDR = 8'd0,
   parameter int        WIDTH   = 32
)
(
   input  logic             clk,
   input  logic             reset,
   input  set_bus_t         i_set,
   output logic [WIDTH-1:0] o_value,
   output logic             o_changed
);

   logic hit;

   assign hit = i_set.stb && (i_set.addr == MY_ADDR);   // strobe for this address.

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         o_value   <= '0;
         o_changed <= 1'b0;
      end
      else
      begin
         o_changed <= hit;
         if (hit)
         begin
            o_value <= i_set.data[WIDTH-1:0];   // low bits only.
         end
      end
   end

endmodule

// File: hdl/pkt_src_pkg.sv
/*
 * shared widths, setting addresses and types for the packet source.
 * payload lengths above MAX_LEN words are not supported by the gate.
 */
package pkt_src_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // sizes.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int DATA_W     = 64;   // one stream word.
   localparam int ROM_DEPTH  = 64;
   localparam int ROM_AW     = 6;
   localparam int GATE_DEPTH = 64;
   localparam int GATE_AW    = 6;
   localparam int MAX_LEN    = 62;   // header plus payload must fit the gate.

   // setting bus addresses.
   localparam logic [7:0] ADDR_SID  = 8'd0;
   localparam logic [7:0] ADDR_LEN  = 8'd1;
   localparam logic [7:0] ADDR_RATE = 8'd2;

   localparam string ROM_FILE = "samples.hex";

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // vector types.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef logic [7:0]        set_addr_t;
   typedef logic [31:0]       set_data_t;
   typedef logic [31:0]       sid_t;
   typedef logic [15:0]       len_t;      // payload length in words.
   typedef logic [15:0]       rate_t;
   typedef logic [11:0]       seqnum_t;
   typedef logic [DATA_W-1:0] word_t;
   typedef logic [ROM_AW-1:0] rom_addr_t;

   // source FSM states.
   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_HEAD = 2'd1,
      ST_DATA = 2'd2
   } src_state_t;

   // setting bus, one write per strobe.
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

   // stream payload; tvalid and tready run as separate wires.
   typedef struct packed {
      word_t tdata;
      logic  tlast;
   } stream_t;

endpackage
